// File: build.f
verilog/mvb_pkg.sv
verilog/demux_pkg.sv
verilog/mvb_unpack_stage.sv
verilog/mvb_steer_stage.sv
verilog/mvb_tx_stage.sv
verilog/mvb_demux_top.sv
bench/mvb_demux_checker.sv
bench/mvb_demux_tb.sv

// File: Bender.yml
package:
  name: mvb_demux

sources:
  - verilog/mvb_pkg.sv
  - verilog/demux_pkg.sv
  - verilog/mvb_unpack_stage.sv
  - verilog/mvb_steer_stage.sv
  - verilog/mvb_tx_stage.sv
  - verilog/mvb_demux_top.sv
  - target: simulation
    files:
      - bench/mvb_demux_checker.sv
      - bench/mvb_demux_tb.sv

// File: bench/mvb_demux_tb.sv
/*
 * MVB demultiplexer testbench.
 * Random words with random source pauses, first with all ports ready and
 * then under random port back-pressure, followed by a full drain.
 */

module mvb_demux_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mvb_pkg::*;
    import demux_pkg::*;

    localparam int unsigned ITEMS      = 4;
    localparam int unsigned TX_PORTS   = 4;
    localparam int unsigned OUTPUT_REG = 1;

    localparam int WORDS_FREE     = 150; // words with every port ready.
    localparam int WORDS_STALL    = 250; // words under random back-pressure.
    localparam int TIMEOUT_CYCLES = 10 * (WORDS_FREE + WORDS_STALL) + 100;

    logic                                             clk = 1'b0;
    logic                                             rst_n;
    raw_item_t [ITEMS-1:0]                            rx_data;
    logic [ITEMS-1:0]                                 rx_vld;
    logic                                             rx_src_rdy;
    logic                                             rx_dst_rdy;
    logic [TX_PORTS-1:0][ITEMS-1:0][ITEM_DATA_W-1:0]  tx_data;
    port_mask_t [TX_PORTS-1:0][ITEMS-1:0]             tx_vld;
    logic [TX_PORTS-1:0]                              tx_src_rdy;
    logic [TX_PORTS-1:0]                              tx_dst_rdy;
    drop_cnt_t                                        drop_cnt;
    int                                               data_errors;
    int                                               drop_errors;
    int                                               other_errors;
    logic [TX_PORTS-1:0]                              busy;
    integer                                           seed;
    int                                               cycle_cnt = 0;

    always #20 clk = ~clk;

    mvb_demux_top #(
        .ITEMS      (ITEMS),
        .TX_PORTS   (TX_PORTS),
        .OUTPUT_REG (OUTPUT_REG)
    ) i_mvb_demux_top (
        .CLK        (clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_vld     (rx_vld),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx_data    (tx_data),
        .tx_vld     (tx_vld),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy),
        .drop_cnt   (drop_cnt)
    );

    mvb_demux_checker #(
        .ITEMS    (ITEMS),
        .TX_PORTS (TX_PORTS)
    ) i_checker (.*);

    task automatic print_counts();
        $display("data errors: %0d, drop errors: %0d, other errors: %0d",
                 data_errors, drop_errors, other_errors);
    endtask

    // about one selector in eight points past the last port.
    task automatic put_random_word();
        raw_item_t [ITEMS-1:0] word;
        for (int i = 0; i < ITEMS; i++) begin
            word[i].data = ITEM_DATA_W'($random(seed));
            if ((($random(seed) & 7) == 0) && TX_PORTS < MAX_PORTS) begin
                word[i].sel = SEL_W'(TX_PORTS + $unsigned($random(seed)) % (MAX_PORTS - TX_PORTS));
            end else begin
                word[i].sel = SEL_W'($unsigned($random(seed)) % TX_PORTS);
            end
        end
        rx_data    <= word;
        rx_vld     <= ITEMS'($random(seed));
        rx_src_rdy <= 1'b1;
    endtask

    // each word stays on the bus until the DUT takes it.
    task automatic drive_words(input int count, input bit stall);
        int sent;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            if (rx_src_rdy && rx_dst_rdy) begin
                sent++;
            end
            if (sent == count) begin
                rx_src_rdy <= 1'b0;
            end else if (!rx_src_rdy || rx_dst_rdy) begin
                if (($random(seed) & 3) != 0) begin
                    put_random_word();
                end else begin
                    rx_src_rdy <= 1'b0; // a pause on the input.
                end
            end
            tx_dst_rdy <= stall ? TX_PORTS'($random(seed) | $random(seed)) : '1;
        end
    endtask

    initial begin
        seed       = 32'h1718_bcb5;
        rst_n      = 1'b0;
        rx_data    = '0;
        rx_vld     = '0;
        rx_src_rdy = 1'b0;
        tx_dst_rdy = '0;
        repeat (16) @(posedge clk);
        rst_n      <= 1'b1;
        tx_dst_rdy <= '1;
        drive_words(WORDS_FREE, 1'b0);
        drive_words(WORDS_STALL, 1'b1);
        @(posedge clk);
        tx_dst_rdy <= '1; // drain with every port ready.
        while (busy != '0 || tx_src_rdy != '0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        print_counts();
        if (data_errors + drop_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("The run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            for (int p = 0; p < TX_PORTS; p++) begin
                if (busy[p]) begin
                    $display("Port %0d still waits for expected words.", p);
                end
            end
            print_counts();
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

// File: bench/mvb_demux_checker.sv
/*
 * MVB demultiplexer checker.
 * Models the routing with one queue of expected words per output port and
 * compares every tx transfer, the drop counter and the reset state.
 */

module mvb_demux_checker #(
    parameter int unsigned ITEMS    = 4,
    parameter int unsigned TX_PORTS = 4
) (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  mvb_pkg::raw_item_t [ITEMS-1:0]                            rx_data,
    input  logic [ITEMS-1:0]                                          rx_vld,
    input  logic                                                      rx_src_rdy,
    input  logic                                                      rx_dst_rdy,
    input  logic [TX_PORTS-1:0][ITEMS-1:0][mvb_pkg::ITEM_DATA_W-1:0]  tx_data,
    input  demux_pkg::port_mask_t [TX_PORTS-1:0][ITEMS-1:0]           tx_vld,
    input  logic [TX_PORTS-1:0]                                       tx_src_rdy,
    input  logic [TX_PORTS-1:0]                                       tx_dst_rdy,
    input  demux_pkg::drop_cnt_t                                      drop_cnt,
    output int                                                        data_errors,
    output int                                                        drop_errors,
    output int                                                        other_errors,
    output logic [TX_PORTS-1:0]                                       busy
);
    timeunit 1ns;
    timeprecision 1ps;

    import mvb_pkg::*;
    import demux_pkg::*;

    localparam int STALL_LIMIT = 100;                       // longest allowed rx stall.
    localparam int DROP_MAX    = 2 ** $bits(drop_cnt_t) - 1; // the counter saturates here.

    typedef struct packed {
        logic [ITEMS-1:0]                  vld;
        logic [ITEMS-1:0][ITEM_DATA_W-1:0] data;
    } tx_word_t;

    tx_word_t exp_q [TX_PORTS][$]; // expected words per port with the oldest first.
    int       n_data       = 0;
    int       n_drop       = 0;
    int       n_other      = 0;
    int       drop_model   = 0;
    int       stall_cycles = 0;
    logic     after_reset  = 1'b0;

    assign data_errors  = n_data;
    assign drop_errors  = n_drop;
    assign other_errors = n_other;

    // the word that port p must see for the input word on the bus.
    function automatic tx_word_t expected_word(input int p);
        tx_word_t w;
        w = '0;
        for (int i = 0; i < ITEMS; i++) begin
            if (rx_vld[i] && rx_data[i].sel == p) begin
                w.vld[i]  = 1'b1;
                w.data[i] = rx_data[i].data;
            end
        end
        return w;
    endfunction

    // Data in slots without a valid bit is not compared.
    function automatic tx_word_t observed_word(input int p);
        tx_word_t w;
        w = '0;
        for (int i = 0; i < ITEMS; i++) begin
            w.vld[i] = tx_vld[p][i];
            if (tx_vld[p][i]) begin
                w.data[i] = tx_data[p][i];
            end
        end
        return w;
    endfunction

    //////////////////////////////
    // compare at the falling edge
    //////////////////////////////

    always @(negedge clk) begin
        tx_word_t exp_w;
        tx_word_t act_w;
        int       exp_drop;
        if (!rst_n || after_reset) begin
            if (tx_src_rdy !== '0 || drop_cnt !== '0 || rx_dst_rdy !== 1'b1) begin
                n_other++;
                $display("Error [reset state] expected tx_src_rdy=0 drop_cnt=0 rx_dst_rdy=1, %s",
                         $sformatf("actual tx_src_rdy=%b drop_cnt=%0d rx_dst_rdy=%b",
                                   tx_src_rdy, drop_cnt, rx_dst_rdy));
            end
        end
        after_reset = !rst_n;
        if (rst_n) begin
            exp_drop = (drop_model > DROP_MAX) ? DROP_MAX : drop_model;
            if (drop_cnt !== drop_cnt_t'(exp_drop)) begin
                n_drop++;
                $display("Error [drops] expected drop_cnt=%0d, actual %0d", exp_drop, drop_cnt);
            end
            for (int p = 0; p < TX_PORTS; p++) begin
                if (tx_src_rdy[p] && tx_dst_rdy[p]) begin
                    act_w = observed_word(p);
                    if (exp_q[p].size() == 0) begin
                        n_other++;
                        $display("Port %0d delivered a word that no input asked for.", p);
                    end else begin
                        exp_w = exp_q[p].pop_front();
                        if (act_w !== exp_w) begin
                            n_data++;
                            $display("Error [routing] port %0d expected %h, actual %h",
                                     p, exp_w, act_w);
                        end
                    end
                end
            end
            if (rx_src_rdy && rx_dst_rdy) begin // the word is taken at the next edge.
                for (int i = 0; i < ITEMS; i++) begin
                    drop_model += (rx_vld[i] && rx_data[i].sel >= TX_PORTS) ? 1 : 0;
                end
                for (int p = 0; p < TX_PORTS; p++) begin
                    exp_w = expected_word(p);
                    if (exp_w.vld != '0) begin
                        exp_q[p].push_back(exp_w);
                    end
                end
            end
            stall_cycles = rx_dst_rdy ? 0 : stall_cycles + 1;
            if (stall_cycles == STALL_LIMIT) begin
                n_other++;
                $display("rx_dst_rdy stayed low for %0d cycles in a row.", STALL_LIMIT);
            end
        end
        for (int p = 0; p < TX_PORTS; p++) begin
            busy[p] = (exp_q[p].size() != 0);
        end
    end

endmodule

// File: verilog/mvb_demux_top.sv
/*
 * MVB demultiplexer.
 * Routes every valid item of an input word to the output port named by
 * its selector through the unpack, steer and transmit stages.
 */

module mvb_demux_top #(
    parameter int unsigned ITEMS      = 4,
    parameter int unsigned TX_PORTS   = 4,
    parameter int unsigned OUTPUT_REG = 1
) (
    input  logic                                                      CLK,
    input  logic                                                      rst_n,

    input  mvb_pkg::raw_item_t [ITEMS-1:0]                            rx_data,
    input  logic [ITEMS-1:0]                                          rx_vld,
    input  logic                                                      rx_src_rdy,
    output logic                                                      rx_dst_rdy,

    output logic [TX_PORTS-1:0][ITEMS-1:0][mvb_pkg::ITEM_DATA_W-1:0]  tx_data,
    output demux_pkg::port_mask_t [TX_PORTS-1:0][ITEMS-1:0]           tx_vld,
    output logic [TX_PORTS-1:0]                                       tx_src_rdy,
    input  logic [TX_PORTS-1:0]                                       tx_dst_rdy,

    output demux_pkg::drop_cnt_t                                      drop_cnt
);

    import mvb_pkg::*;
    import demux_pkg::*;

    mvb_item_t [ITEMS-1:0]                unp_items; // unpack to steer.
    logic                                 unp_valid;
    logic                                 unp_ready;

    logic [ITEMS-1:0][ITEM_DATA_W-1:0]    str_data;  // steer to transmit.
    port_mask_t [TX_PORTS-1:0][ITEMS-1:0] str_mask;
    logic                                 str_valid;
    logic [TX_PORTS-1:0]                  str_ready;

    mvb_unpack_stage #(
        .ITEMS      (ITEMS),
        .TX_PORTS   (TX_PORTS)
    ) i_unpack (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .in_data    (rx_data),
        .in_vld     (rx_vld),
        .in_src_rdy (rx_src_rdy),
        .in_dst_rdy (rx_dst_rdy),
        .out_items  (unp_items),
        .out_valid  (unp_valid),
        .out_ready  (unp_ready),
        .drop_cnt   (drop_cnt)
    );

    mvb_steer_stage #(
        .ITEMS      (ITEMS),
        .TX_PORTS   (TX_PORTS)
    ) i_steer (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .in_items   (unp_items),
        .in_valid   (unp_valid),
        .in_ready   (unp_ready),
        .out_data   (str_data),
        .out_mask   (str_mask),
        .out_valid  (str_valid),
        .port_ready (str_ready)
    );

    mvb_tx_stage #(
        .ITEMS      (ITEMS),
        .TX_PORTS   (TX_PORTS),
        .OUTPUT_REG (OUTPUT_REG)
    ) i_tx (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .in_data    (str_data),
        .in_mask    (str_mask),
        .in_valid   (str_valid),
        .port_ready (str_ready),
        .tx_data    (tx_data),
        .tx_vld     (tx_vld),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

endmodule

// File: verilog/mvb_tx_stage.sv
/*
 * MVB transmit stage.
 * One word buffer per output port, loaded when the released word targets
 * that port. With OUTPUT_REG at 0 the buffers are left out and the steer
 * stage drives the output buses directly.
 */

module mvb_tx_stage #(
    parameter int unsigned ITEMS      = 4,
    parameter int unsigned TX_PORTS   = 4,
    parameter int unsigned OUTPUT_REG = 1
) (
    input  logic                                                      CLK,
    input  logic                                                      rst_n,

    input  logic [ITEMS-1:0][mvb_pkg::ITEM_DATA_W-1:0]                in_data,
    input  demux_pkg::port_mask_t [TX_PORTS-1:0][ITEMS-1:0]           in_mask,
    input  logic                                                      in_valid,
    output logic [TX_PORTS-1:0]                                       port_ready,

    output logic [TX_PORTS-1:0][ITEMS-1:0][mvb_pkg::ITEM_DATA_W-1:0]  tx_data,
    output demux_pkg::port_mask_t [TX_PORTS-1:0][ITEMS-1:0]           tx_vld,
    output logic [TX_PORTS-1:0]                                       tx_src_rdy,
    input  logic [TX_PORTS-1:0]                                       tx_dst_rdy
);

    import mvb_pkg::*;
    import demux_pkg::*;

    logic [TX_PORTS-1:0] present; // ports the offered word targets.
    logic [TX_PORTS-1:0] port_ok; // ready, or not a target of the offered word.

    always_comb begin
        for (int p = 0; p < TX_PORTS; p++) begin
            present[p] = |in_mask[p];
        end
    end

    assign port_ok = port_ready | ~present;

    if (OUTPUT_REG != 0) begin : g_out_reg

        //////////////////////////////
        // registered outputs
        //////////////////////////////

        logic release_word; // the steer stage hands its word over this cycle.

        assign release_word = in_valid && &port_ok;

        for (genvar p = 0; p < TX_PORTS; p++) begin : g_port
            logic                              full;
            logic                              load;
            logic [ITEMS-1:0][ITEM_DATA_W-1:0] data_q;
            port_mask_t [ITEMS-1:0]            vld_q;

            assign load          = release_word && present[p];
            assign port_ready[p] = !full || tx_dst_rdy[p];
            assign tx_src_rdy[p] = full;
            assign tx_data[p]    = data_q;
            assign tx_vld[p]     = vld_q;

            always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                    full <= 1'b0;
                end else if (load) begin
                    full <= 1'b1;
                end else if (tx_dst_rdy[p]) begin
                    full <= 1'b0;
                end
            end

            always_ff @(posedge CLK) begin
                if (load) begin
                    data_q <= in_data;
                    vld_q  <= in_mask[p];
                end
            end
        end

    end else begin : g_bypass

        //////////////////////////////
        // direct outputs
        //////////////////////////////

        assign port_ready = tx_dst_rdy;

        // a port shows the word only while every other target can take it too.
        always_comb begin
            logic [TX_PORTS-1:0] others_ok;
            for (int p = 0; p < TX_PORTS; p++) begin
                others_ok     = port_ok;
                others_ok[p]  = 1'b1;
                tx_src_rdy[p] = in_valid && present[p] && &others_ok;
                tx_data[p]    = in_data;
                tx_vld[p]     = in_mask[p];
            end
        end

    end

endmodule

// File: verilog/mvb_steer_stage.sv
/*
 * MVB steer stage.
 * Decodes the selector of every item into per-port valid masks and holds
 * one word. The word leaves only when all ports it targets are ready.
 */

module mvb_steer_stage #(
    parameter int unsigned ITEMS    = 4,
    parameter int unsigned TX_PORTS = 4
) (
    input  logic                                              CLK,
    input  logic                                              rst_n,

    input  mvb_pkg::mvb_item_t [ITEMS-1:0]                    in_items,
    input  logic                                              in_valid,
    output logic                                              in_ready,

    output logic [ITEMS-1:0][mvb_pkg::ITEM_DATA_W-1:0]        out_data,
    output demux_pkg::port_mask_t [TX_PORTS-1:0][ITEMS-1:0]   out_mask,
    output logic                                              out_valid,
    input  logic [TX_PORTS-1:0]                               port_ready
);

    import mvb_pkg::*;
    import demux_pkg::*;

    logic [ITEMS-1:0][MAX_PORTS-1:0]      sel_hot; // one-hot selector per item.
    port_mask_t [TX_PORTS-1:0][ITEMS-1:0] mask_d;
    logic [TX_PORTS-1:0]                  present; // ports the held word targets.
    logic                                 load;
    logic                                 leave;
    logic                                 full;

    //////////////////////////////
    // selector decode
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < ITEMS; i++) begin
            sel_hot[i]                  = '0;
            sel_hot[i][in_items[i].sel] = in_items[i].vld;
        end
        // only the lower TX_PORTS lines of the decode are real ports.
        for (int p = 0; p < TX_PORTS; p++) begin
            for (int i = 0; i < ITEMS; i++) begin
                mask_d[p][i] = sel_hot[i][p];
            end
        end
    end

    //////////////////////////////
    // word register
    //////////////////////////////

    always_comb begin
        for (int p = 0; p < TX_PORTS; p++) begin
            present[p] = |out_mask[p];
        end
    end

    // ports that get nothing from the held word do not hold it back.
    assign leave     = full && &(port_ready | ~present);
    assign in_ready  = !full || leave;
    assign load      = in_valid && in_ready;
    assign out_valid = full && |present;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= |mask_d; // a word without routable items is dropped here.
        end else if (leave) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            out_mask <= mask_d;
            for (int i = 0; i < ITEMS; i++) begin
                out_data[i] <= in_items[i].data;
            end
        end
    end

endmodule

// File: verilog/mvb_unpack_stage.sv
/*
 * MVB unpack stage.
 * Registers each accepted input word as item records. Items whose selector
 * addresses no existing port lose their valid bit and are counted as drops.
 */

module mvb_unpack_stage #(
    parameter int unsigned ITEMS    = 4,
    parameter int unsigned TX_PORTS = 4
) (
    input  logic                           CLK,
    input  logic                           rst_n,

    input  mvb_pkg::raw_item_t [ITEMS-1:0] in_data,
    input  logic [ITEMS-1:0]               in_vld,
    input  logic                           in_src_rdy,
    output logic                           in_dst_rdy,

    output mvb_pkg::mvb_item_t [ITEMS-1:0] out_items,
    output logic                           out_valid,
    input  logic                           out_ready,

    output demux_pkg::drop_cnt_t           drop_cnt
);

    import mvb_pkg::*;
    import demux_pkg::*;

    localparam int unsigned CNT_W = $bits(drop_cnt_t);
    localparam int unsigned NUM_W = $clog2(ITEMS + 1);

    // selector values from this one up address no port.
    localparam logic [SEL_W:0] PORT_LIM = (SEL_W + 1)'(TX_PORTS);

    logic                  accept;
    logic                  full;
    mvb_item_t [ITEMS-1:0] items_d;
    logic [NUM_W-1:0]      num_drop; // dropped items in the word on the input.
    logic [CNT_W:0]        cnt_sum;

    //////////////////////////////
    // handshake
    //////////////////////////////

    assign in_dst_rdy = !full || out_ready; // room when empty or when the word leaves.
    assign accept     = in_src_rdy && in_dst_rdy;
    assign out_valid  = full;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    //////////////////////////////
    // slot split
    //////////////////////////////

    always_comb begin
        num_drop = '0;
        for (int i = 0; i < ITEMS; i++) begin
            items_d[i].data = in_data[i].data;
            items_d[i].sel  = in_data[i].sel;
            items_d[i].vld  = in_vld[i] && ({1'b0, in_data[i].sel} < PORT_LIM);
            if (in_vld[i] && !items_d[i].vld) begin
                num_drop = num_drop + 1'b1; // valid item without a target port.
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            out_items <= items_d;
        end
    end

    // the counter stops at all ones instead of wrapping.
    assign cnt_sum = {1'b0, drop_cnt} + (CNT_W + 1)'(num_drop);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt <= '0;
        end else if (accept) begin
            drop_cnt <= cnt_sum[CNT_W] ? '1 : cnt_sum[CNT_W-1:0];
        end
    end

endmodule

// File: verilog/demux_pkg.sv
/*
 * Demultiplexer types.
 * Port count limit, the element of a per-port item mask and the
 * drop counter type.
 */

package demux_pkg;

    //////////////////////////////
    // port limits
    //////////////////////////////

    // the selector field can address this many output ports at most.
    localparam int unsigned MAX_PORTS = 2 ** mvb_pkg::SEL_W;

    localparam int unsigned DROP_CNT_W = 16; // width of the drop counter.

    //////////////////////////////
    // per-port word types
    //////////////////////////////

    // One bit of a port mask.
    // It is set when that item slot carries data for the port.
    // Modules build whole masks as port_mask_t [ITEMS-1:0].
    typedef logic port_mask_t;

    typedef logic [DROP_CNT_W-1:0] drop_cnt_t; // saturating count of dropped items.

endpackage

// File: verilog/mvb_pkg.sv
/*
 * MVB bus types.
 * Field widths of one item, the layout of a raw input slot and the item
 * record that travels between the demultiplexer stages.
 */

package mvb_pkg;

    //////////////////////////////
    // field widths
    //////////////////////////////

    localparam int unsigned ITEM_DATA_W = 16; // payload bits of one item.
    localparam int unsigned SEL_W       = 3;  // bits of the output port selector.

    //////////////////////////////
    // item layouts
    //////////////////////////////

    // the selector sits above the data in a slot as it arrives on the bus.
    typedef struct packed {
        logic [SEL_W-1:0]       sel;
        logic [ITEM_DATA_W-1:0] data;
    } raw_item_t;

    // An unpacked item with its own valid bit.
    // vld is already cleared for items that address no existing port.
    typedef struct packed {
        logic [ITEM_DATA_W-1:0] data;
        logic [SEL_W-1:0]       sel;
        logic                   vld;
    } mvb_item_t;

endpackage
